// ==== clint.sv ====
// core-local timer; memory-mapped mtime and mtimecmp with a registered timer interrupt level.
`timescale 1ns/1ps
`default_nettype none

module clint (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              sel,
	input  logic              mem_r,
	input  logic              mem_w,
	input  rv_mem_pkg::word_t mem_addr,
	input  rv_mem_pkg::word_t mem_wdata,
	input  logic [7:0]        wmask,
	output rv_mem_pkg::word_t rdata,
	output logic              timer_irq
);
	import rv_mem_pkg::*;

	word_t mtime;
	word_t mtimecmp;
	word_t off;
	logic  hit_time;
	logic  hit_cmp;

	assign off      = mem_addr - clint_base;
	assign hit_time = sel && off == mtime_off;
	assign hit_cmp  = sel && off == mtimecmp_off;

	// free-running, except on the edge that writes it.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtime <= '0;
		end else if (mem_w && hit_time) begin
			mtime <= apply_wmask(mtime, mem_wdata, wmask);
		end else begin
			mtime <= mtime + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtimecmp <= '1; // keeps the interrupt quiet out of reset.
		end else if (mem_w && hit_cmp) begin
			mtimecmp <= apply_wmask(mtimecmp, mem_wdata, wmask);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer_irq <= 1'b0;
		end else begin
			timer_irq <= mtime >= mtimecmp;
		end
	end

	// unmapped offsets read as zero.
	always_ff @(posedge clk) begin
		if (sel && mem_r) begin
			if (hit_time) begin
				rdata <= mtime;
			end else if (hit_cmp) begin
				rdata <= mtimecmp;
			end else begin
				rdata <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== data_mem.sv ====
// doubleword RAM behind the memory stage; byte-masked writes and one-cycle registered reads.
`timescale 1ns/1ps
`default_nettype none

module data_mem #(
	parameter int dmem_words = 256
) (
	input  logic              clk,
	input  logic              sel,
	input  logic              mem_r,
	input  logic              mem_w,
	input  rv_mem_pkg::word_t mem_addr,
	input  rv_mem_pkg::word_t mem_wdata,
	input  logic [7:0]        wmask,
	output rv_mem_pkg::word_t rdata
);
	import rv_mem_pkg::*;

	localparam int idx_w = $clog2(dmem_words);

	word_t            mem [dmem_words];
	logic [idx_w-1:0] idx;

	// depth is a power of two, so upper address bits just wrap.
	assign idx = mem_addr[idx_w+2:3];

	always_ff @(posedge clk) begin
		if (sel && mem_w) begin
			mem[idx] <= apply_wmask(mem[idx], mem_wdata, wmask);
		end
	end

	always_ff @(posedge clk) begin
		if (sel && mem_r) begin
			rdata <= mem[idx]; // valid the cycle after the request.
		end
	end

	assert property (@(posedge clk) (sel && mem_w) |-> wmask != 8'h00)
		else $error("data_mem: write with empty byte mask");

endmodule

`default_nettype wire

// ==== key_mux.sv ====
// keyed lookup mux; gives the value of the first matching key, or the default, for any payload type.
`timescale 1ns/1ps
`default_nettype none

module key_mux #(
	parameter int  n_keys    = 2,
	parameter int  key_w     = 1,
	parameter type payload_t = logic
) (
	input  logic [key_w-1:0] key,
	input  payload_t         default_out,
	input  logic [key_w-1:0] keys [n_keys],
	input  payload_t         values [n_keys],
	output payload_t         out
);

	logic hit;

	// lowest index wins when keys repeat.
	always_comb begin
		hit = 1'b0;
		out = default_out;
		for (int i = 0; i < n_keys; i++) begin
			if (!hit && keys[i] == key) begin
				out = values[i];
				hit = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== mau.sv ====
// memory access unit; decodes loads and stores, drives the request and extends the returned load data.
`timescale 1ns/1ps
`default_nettype none

module mau (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [6:0]        opcode,
	input  logic [2:0]        funct3,
	input  rv_mem_pkg::word_t src2,
	input  rv_mem_pkg::word_t alu_result,
	output logic              mem_r,
	output logic              mem_w,
	output rv_mem_pkg::word_t mem_addr,
	output rv_mem_pkg::word_t mem_wdata,
	output logic [7:0]        wmask,
	input  rv_mem_pkg::word_t mem_rdata,
	output rv_mem_pkg::word_t ld_data,
	output logic              ld_valid
);
	import rv_mem_pkg::*;

	typedef logic [7:0]  byte_t;
	typedef logic [15:0] half_t;
	typedef logic [31:0] word32_t;

	logic       rd_q;
	logic [2:0] f3_q;
	logic [2:0] off_q;

	logic [2:0] b_keys [8];
	byte_t      b_vals [8];
	logic [2:0] h_keys [7];
	half_t      h_vals [7];
	logic [2:0] w_keys [5];
	word32_t    w_vals [5];
	byte_t      ld_b;
	half_t      ld_h;
	word32_t    ld_w;

	logic [2:0] ld_keys [7];
	word_t      ld_vals [7];
	logic [2:0] st_keys [4];
	byte_t      st_vals [4];

	assign mem_r     = opcode == op_load;
	assign mem_w     = opcode == op_store;
	assign mem_addr  = (mem_r || mem_w) ? alu_result : '0;
	assign mem_wdata = mem_w ? src2 : '0;

	// store mask; shifted past bit 7 is simply lost.
	assign st_keys[0] = f3_sb;
	assign st_keys[1] = f3_sh;
	assign st_keys[2] = f3_sw;
	assign st_keys[3] = f3_sd;
	assign st_vals[0] = 8'b0000_0001 << mem_addr[2:0];
	assign st_vals[1] = 8'b0000_0011 << mem_addr[2:0];
	assign st_vals[2] = 8'b0000_1111 << mem_addr[2:0];
	assign st_vals[3] = 8'b1111_1111;

	key_mux #(.n_keys(4), .key_w(3), .payload_t(byte_t)) u_wmask (
		.key         (funct3),
		.default_out (8'h00),
		.keys        (st_keys),
		.values      (st_vals),
		.out         (wmask)
	);

	// load state held for the returning data.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_q <= 1'b0;
		end else begin
			rd_q <= mem_r;
		end
	end

	always_ff @(posedge clk) begin
		if (mem_r) begin
			f3_q  <= funct3;
			off_q <= mem_addr[2:0];
		end
	end

	assign ld_valid = rd_q;

	// lanes at each byte offset; wider lanes stop at the word edge.
	for (genvar i = 0; i < 8; i++) begin : g_lane
		assign b_keys[i] = 3'(i);
		assign b_vals[i] = mem_rdata[8*i +: 8];
		if (i < 7) begin : g_half
			assign h_keys[i] = 3'(i);
			assign h_vals[i] = mem_rdata[8*i +: 16];
		end
		if (i < 5) begin : g_word
			assign w_keys[i] = 3'(i);
			assign w_vals[i] = mem_rdata[8*i +: 32];
		end
	end

	key_mux #(.n_keys(8), .key_w(3), .payload_t(byte_t)) u_lane_b (
		.key         (off_q),
		.default_out (8'h00),
		.keys        (b_keys),
		.values      (b_vals),
		.out         (ld_b)
	);

	key_mux #(.n_keys(7), .key_w(3), .payload_t(half_t)) u_lane_h (
		.key         (off_q),
		.default_out (16'h0000),
		.keys        (h_keys),
		.values      (h_vals),
		.out         (ld_h)
	);

	key_mux #(.n_keys(5), .key_w(3), .payload_t(word32_t)) u_lane_w (
		.key         (off_q),
		.default_out (32'h0000_0000),
		.keys        (w_keys),
		.values      (w_vals),
		.out         (ld_w)
	);

	assign ld_keys[0] = f3_lb;
	assign ld_keys[1] = f3_lh;
	assign ld_keys[2] = f3_lw;
	assign ld_keys[3] = f3_lbu;
	assign ld_keys[4] = f3_lhu;
	assign ld_keys[5] = f3_lwu;
	assign ld_keys[6] = f3_ld;
	assign ld_vals[0] = {{(xlen-8){ld_b[7]}}, ld_b};
	assign ld_vals[1] = {{(xlen-16){ld_h[15]}}, ld_h};
	assign ld_vals[2] = {{(xlen-32){ld_w[31]}}, ld_w};
	assign ld_vals[3] = {{(xlen-8){1'b0}}, ld_b};
	assign ld_vals[4] = {{(xlen-16){1'b0}}, ld_h};
	assign ld_vals[5] = {{(xlen-32){1'b0}}, ld_w};
	assign ld_vals[6] = mem_rdata;

	key_mux #(.n_keys(7), .key_w(3), .payload_t(word_t)) u_ld_data (
		.key         (f3_q),
		.default_out ('0),
		.keys        (ld_keys),
		.values      (ld_vals),
		.out         (ld_data)
	);

	// a load asks for one of the seven defined widths.
	assert property (@(posedge clk) disable iff (!rst_n) mem_r |-> funct3 != 3'b111)
		else $error("mau: load with undefined funct3");

	// stores come only as byte, half, word or doubleword.
	assert property (@(posedge clk) disable iff (!rst_n) mem_w |-> !funct3[2])
		else $error("mau: store with undefined funct3");

endmodule

`default_nettype wire

// ==== mem_stimulus.txt ====
// columns: opcode funct3 address store_data expected_load, all hex
// expected_load is unused on store lines; store data sits in the lanes it writes.
23 3 80000000 8172E354C536A718 0
03 3 80000000 0 8172E354C536A718
03 0 80000001 0 FFFFFFFFFFFFFFA7
03 4 80000001 0 00000000000000A7
03 1 80000002 0 FFFFFFFFFFFFC536
03 5 80000006 0 0000000000008172
03 2 80000004 0 FFFFFFFF8172E354
03 6 80000000 0 00000000C536A718
03 2 80000001 0 0000000054C536A7
03 0 80000007 0 FFFFFFFFFFFFFF81
03 1 80000007 0 0
03 2 80000005 0 0
03 6 80000006 0 0
03 5 80000007 0 0
23 0 80000003 000000005A000000 0
23 1 80000004 0000BEEF00000000 0
03 3 80000000 0 8172BEEF5A36A718
23 3 80000008 0123456789ABCDEF 0
23 2 8000000C CAFEF00D00000000 0
03 3 80000008 0 CAFEF00D89ABCDEF
03 2 80000008 0 FFFFFFFF89ABCDEF

// ==== mem_subsys_top.sv ====
// memory stage top level; routes mau requests to the RAM or the timer and selects the return data.
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top #(
	parameter int dmem_words = 256
) (
	input  logic              clk,
	input  logic              rst_n,
	input  logic [6:0]        opcode,
	input  logic [2:0]        funct3,
	input  rv_mem_pkg::word_t alu_result,
	input  rv_mem_pkg::word_t src2,
	output rv_mem_pkg::word_t ld_data,
	output logic              ld_valid,
	output logic              timer_irq
);
	import rv_mem_pkg::*;

	logic       mem_r;
	logic       mem_w;
	word_t      mem_addr;
	word_t      mem_wdata;
	word_t      mem_rdata;
	word_t      dmem_rdata;
	word_t      clint_rdata;
	logic [7:0] wmask;
	logic       dmem_sel;
	logic       clint_sel;
	logic       rd_clint_q;

	assign dmem_sel  = mem_addr >= dmem_base;
	assign clint_sel = (mem_addr >= clint_base) && (mem_addr < clint_base + clint_size);

	// region of the read in flight picks the return path.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_clint_q <= 1'b0;
		end else if (mem_r) begin
			rd_clint_q <= clint_sel;
		end
	end

	assign mem_rdata = rd_clint_q ? clint_rdata : dmem_rdata;

	mau u_mau (
		.clk        (clk),
		.rst_n      (rst_n),
		.opcode     (opcode),
		.funct3     (funct3),
		.src2       (src2),
		.alu_result (alu_result),
		.mem_r      (mem_r),
		.mem_w      (mem_w),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.wmask      (wmask),
		.mem_rdata  (mem_rdata),
		.ld_data    (ld_data),
		.ld_valid   (ld_valid)
	);

	data_mem #(.dmem_words(dmem_words)) u_data_mem (
		.clk       (clk),
		.sel       (dmem_sel),
		.mem_r     (mem_r),
		.mem_w     (mem_w),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.wmask     (wmask),
		.rdata     (dmem_rdata)
	);

	clint u_clint (
		.clk       (clk),
		.rst_n     (rst_n),
		.sel       (clint_sel),
		.mem_r     (mem_r),
		.mem_w     (mem_w),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.wmask     (wmask),
		.rdata     (clint_rdata),
		.timer_irq (timer_irq)
	);

endmodule

`default_nettype wire

// ==== project.f ====
rv_mem_pkg.sv
key_mux.sv
mau.sv
data_mem.sv
clint.sv
mem_subsys_top.sv
tb_clock_gen.sv
tb_mem_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tb_mem_subsys -f project.f \
	&& ./obj_dir/Vtb_mem_subsys > sim.log 2>&1 \
	|| echo "build or simulation failed"
cat sim.log 2>/dev/null
grep -q "NO ERRORS" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// ==== rv_mem_pkg.sv ====
// shared word width, opcodes, funct3 codes, address map and byte-merge helper for the memory stage.
`default_nettype none

package rv_mem_pkg;

	localparam int xlen = 64;

	typedef logic [xlen-1:0] word_t;

	localparam logic [6:0] op_load  = 7'b000_0011;
	localparam logic [6:0] op_store = 7'b010_0011;

	// load widths.
	localparam logic [2:0] f3_lb  = 3'b000;
	localparam logic [2:0] f3_lh  = 3'b001;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_ld  = 3'b011;
	localparam logic [2:0] f3_lbu = 3'b100;
	localparam logic [2:0] f3_lhu = 3'b101;
	localparam logic [2:0] f3_lwu = 3'b110;

	// store widths.
	localparam logic [2:0] f3_sb = 3'b000;
	localparam logic [2:0] f3_sh = 3'b001;
	localparam logic [2:0] f3_sw = 3'b010;
	localparam logic [2:0] f3_sd = 3'b011;

	localparam word_t clint_base   = 64'h0000_0000_0200_0000;
	localparam word_t mtimecmp_off = 64'h0000_0000_0000_4000;
	localparam word_t mtime_off    = 64'h0000_0000_0000_bff8;
	localparam word_t clint_size   = 64'h0000_0000_0001_0000;
	localparam word_t dmem_base    = 64'h0000_0000_8000_0000;

	// merge new bytes into old where the mask bit is set.
	function automatic word_t apply_wmask(input word_t old_data, input word_t new_data,
		input logic [7:0] mask);
		word_t merged;
		merged = old_data;
		for (int i = 0; i < 8; i++) begin
			if (mask[i]) begin
				merged[8*i +: 8] = new_data[8*i +: 8];
			end
		end
		return merged;
	endfunction

endpackage

`default_nettype wire

// ==== tb_clock_gen.sv ====
// testbench clock and reset source; instantiate once in the testbench top.
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter int period_ns    = 40,
	parameter int reset_cycles = 3
) (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

	// release on a falling edge, away from the sampling edge.
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

`default_nettype wire

// ==== tb_mem_subsys.sv ====
// testbench top for the memory stage; replays mem_stimulus.txt, then random RAM traffic and timer checks.
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys;
	import rv_mem_pkg::*;

	localparam int    n_entries  = 21;
	localparam int    n_fill     = 16;
	localparam int    n_rand     = 32;
	localparam int    n_sweep    = 56;
	localparam int    max_cycles = n_entries * 2 + (n_fill + n_rand + n_sweep) * 2 + 100;
	localparam word_t fill_base  = dmem_base + 64'h100; // 128-byte aligned.
	localparam word_t cmp_delta  = 64'd12;

	logic       clk;
	logic       rst_n;
	logic [6:0] opcode;
	logic [2:0] funct3;
	word_t      alu_result;
	word_t      src2;
	word_t      ld_data;
	logic       ld_valid;
	logic       timer_irq;

	word_t stim [n_entries*5];
	word_t model [n_fill];
	word_t lcg_state;
	int    n_checks;
	int    n_errors;
	int    cycles;

	tb_clock_gen #(.period_ns(40), .reset_cycles(3)) u_clk (.clk(clk), .rst_n(rst_n));

	mem_subsys_top #(.dmem_words(256)) u_dut (
		.clk        (clk),
		.rst_n      (rst_n),
		.opcode     (opcode),
		.funct3     (funct3),
		.alu_result (alu_result),
		.src2       (src2),
		.ld_data    (ld_data),
		.ld_valid   (ld_valid),
		.timer_irq  (timer_irq)
	);

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 64'd6364136223846793005 + 64'd1442695040888963407;
		return lcg_state;
	endfunction

	// reference lane select and extension.
	function automatic word_t expect_load(input word_t w, input logic [2:0] f3,
		input logic [2:0] off);
		word_t       sh;
		logic [7:0]  b;
		logic [15:0] h;
		logic [31:0] wd;
		sh = w >> {off, 3'b000};
		b  = sh[7:0];
		h  = (off <= 3'd6) ? sh[15:0] : 16'h0000;
		wd = (off <= 3'd4) ? sh[31:0] : 32'h0000_0000; // no lane past the word edge.
		case (f3)
			f3_lb:   return {{56{b[7]}}, b};
			f3_lh:   return {{48{h[15]}}, h};
			f3_lw:   return {{32{wd[31]}}, wd};
			f3_lbu:  return {56'h0, b};
			f3_lhu:  return {48'h0, h};
			f3_lwu:  return {32'h0, wd};
			f3_ld:   return w;
			default: return '0;
		endcase
	endfunction

	task automatic drive(input logic [6:0] op, input logic [2:0] f3, input word_t addr,
		input word_t data);
		opcode     = op;
		funct3     = f3;
		alu_result = addr;
		src2       = data;
	endtask

	task automatic check_value(input string name, input word_t exp, input word_t act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_valid(input string name);
		n_checks++;
		if (ld_valid !== 1'b1) begin
			n_errors++;
			$display("%s: ld_valid was not high in the cycle after the load", name);
		end
	endtask

	// one request cycle, then an idle cycle; load data is picked up at the idle edge.
	task automatic access(input logic [6:0] op, input logic [2:0] f3, input word_t addr,
		input word_t data, output word_t got);
		@(negedge clk);
		drive(op, f3, addr, data);
		@(negedge clk);
		drive(7'h00, 3'b000, '0, '0);
		got = ld_data;
		if (op == op_load) begin
			check_valid($sformatf("load at %h", addr));
		end
	endtask

	initial begin
		word_t      got;
		word_t      r;
		word_t      t;
		logic [3:0] idx;
		logic [2:0] off;
		logic [2:0] f3;
		int         waits;
		drive(7'h00, 3'b000, '0, '0);
		lcg_state = 64'd31862;
		n_checks  = 0;
		n_errors  = 0;
		$readmemh("mem_stimulus.txt", stim);
		while (rst_n !== 1'b1) @(negedge clk);
		check_value("timer_irq after reset", '0, 64'(timer_irq));

		for (int i = 0; i < n_entries; i++) begin
			access(stim[5*i][6:0], stim[5*i+1][2:0], stim[5*i+2], stim[5*i+3], got);
			if (stim[5*i][6:0] == op_load) begin
				check_value($sformatf("stim entry %0d", i), stim[5*i+4], got);
			end
		end

		for (int i = 0; i < n_fill; i++) begin
			r = lcg_next();
			model[i][63:32] = r[63:32];
			r = lcg_next();
			model[i][31:0] = r[63:32];
			access(op_store, f3_sd, {fill_base[63:7], 4'(i), 3'b000}, model[i], got);
		end
		for (int j = 0; j < n_rand; j++) begin
			r   = lcg_next();
			idx = r[63:60];
			off = r[58:56];
			f3  = r[54:52];
			if (f3 == 3'b111) begin
				f3 = f3_ld;
			end
			access(op_load, f3, {fill_base[63:7], idx, off}, '0, got);
			check_value($sformatf("random load %0d f3 %0d off %0d", j, f3, off),
				expect_load(model[idx], f3, off), got);
		end

		// every load width at every byte offset of one stored word.
		for (int k = 0; k < 64; k++) begin
			off = k[2:0];
			f3  = k[5:3];
			if (f3 != 3'b111) begin
				access(op_load, f3, {fill_base[63:7], 4'd5, off}, '0, got);
				check_value($sformatf("sweep load f3 %0d off %0d", f3, off),
					expect_load(model[5], f3, off), got);
			end
		end

		// irq is registered, so it shows one edge after mtime reaches mtimecmp.
		access(op_load, f3_ld, clint_base + mtime_off, '0, t);
		access(op_store, f3_sd, clint_base + mtimecmp_off, t + cmp_delta, got);
		waits = 0;
		while (timer_irq !== 1'b1 && waits < 40) begin
			@(negedge clk);
			waits++;
		end
		check_value("timer_irq rise cycles", cmp_delta - 64'd2, 64'(waits));

		drive(op_load, f3_ld, {fill_base[63:7], 4'd3, 3'd0}, '0);
		@(negedge clk);
		check_valid("back-to-back RAM load");
		check_value("back-to-back RAM load", model[3], ld_data);
		drive(op_load, f3_ld, clint_base + mtimecmp_off, '0);
		@(negedge clk);
		check_valid("back-to-back clint load");
		check_value("back-to-back clint load", t + cmp_delta, ld_data);
		drive(7'h00, 3'b000, '0, '0);

		$display("checks %0d, errors %0d", n_checks, n_errors);
		if (n_errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

	initial begin
		cycles = 0;
		while (cycles < max_cycles) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: test did not finish within %0d cycles", max_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire
